// File: logic/adam_ctrl_pkg.sv
/* Shared types and constants of the controller front end. Every RTL file
   imports this package for widths, keypad indices, key codes and PS/2 codes */
package adam_ctrl_pkg;

        // ========================================================================
        // Widths and keypad layout
        // ========================================================================
        typedef logic [31:0] joy_word_t;
        typedef logic [19:0] keypad_t;
        typedef logic [3:0]  key_code_t;
        typedef logic [7:0]  ps2_code_t;

        // Digits 0 to 9 sit at KP_DIGIT0 + n
        localparam int KP_DIGIT0 = 0;
        localparam int KP_STAR   = 10;
        localparam int KP_NUMBER = 11;
        localparam int KP_PURPLE = 12;
        localparam int KP_BLUE   = 13;
        // Up, down, left, right follow in that order
        localparam int KP_DIR_UP = 14;
        localparam int KP_FIRE1  = 18;
        localparam int KP_FIRE2  = 19;

        // ========================================================================
        // Console key codes, returned while the keypad select is low
        // ========================================================================
        localparam key_code_t KEY_CODE_0      = 4'b0011;
        localparam key_code_t KEY_CODE_1      = 4'b1110;
        localparam key_code_t KEY_CODE_2      = 4'b1101;
        localparam key_code_t KEY_CODE_3      = 4'b0110;
        localparam key_code_t KEY_CODE_4      = 4'b0001;
        localparam key_code_t KEY_CODE_5      = 4'b1001;
        localparam key_code_t KEY_CODE_6      = 4'b0111;
        localparam key_code_t KEY_CODE_7      = 4'b1100;
        localparam key_code_t KEY_CODE_8      = 4'b1000;
        localparam key_code_t KEY_CODE_9      = 4'b1011;
        localparam key_code_t KEY_CODE_STAR   = 4'b1010;
        localparam key_code_t KEY_CODE_NUMBER = 4'b0101;
        localparam key_code_t KEY_CODE_PURPLE = 4'b0100;
        localparam key_code_t KEY_CODE_BLUE   = 4'b0010;
        localparam key_code_t KEY_NONE        = 4'b1111;

        // Indexed by keypad entry, digit 0 through blue
        localparam key_code_t KEY_CODE_TBL [0:13] = '{
                KEY_CODE_0, KEY_CODE_1, KEY_CODE_2, KEY_CODE_3, KEY_CODE_4,
                KEY_CODE_5, KEY_CODE_6, KEY_CODE_7, KEY_CODE_8, KEY_CODE_9,
                KEY_CODE_STAR, KEY_CODE_NUMBER, KEY_CODE_PURPLE, KEY_CODE_BLUE
        };

        // PS/2 set 2 make codes, digit tables indexed by digit value
        localparam ps2_code_t PS2_DIGIT_MAIN [0:9] = '{
                8'h45, 8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e, 8'h36, 8'h3d, 8'h3e, 8'h46
        };
        localparam ps2_code_t PS2_DIGIT_PAD [0:9] = '{
                8'h70, 8'h69, 8'h72, 8'h7a, 8'h6b, 8'h73, 8'h74, 8'h6c, 8'h75, 8'h7d
        };
        localparam ps2_code_t PS2_STAR   = 8'h7c;
        localparam ps2_code_t PS2_LSHIFT = 8'h12;
        localparam ps2_code_t PS2_RSHIFT = 8'h59;
        localparam ps2_code_t PS2_MINUS  = 8'h7b;

        // ========================================================================
        // Grouped signals
        // ========================================================================
        typedef struct packed {
                logic      toggle;
                logic      pressed;
                logic      extended;
                ps2_code_t code;
        } ps2_key_t;

        typedef struct packed {
                logic [9:0] digit;
                logic       star;
                logic       shift;
                logic       minus;
        } emu_buttons_t;

        typedef struct packed {
                key_code_t code;
                logic      fire_n;
        } port_out_t;

endpackage

// File: logic/ps2_keypad_emu.sv
/* Keypad emulation from the PS/2 keyboard. Make and break events set and
   clear held button states for the joystick mapper */
`timescale 1ns/10ps

module ps2_keypad_emu (
        input  logic                        clk_sys,
        input  logic                        reset_i,
        input  adam_ctrl_pkg::ps2_key_t     ps2_key_i,
        output adam_ctrl_pkg::emu_buttons_t buttons_o
);

        import adam_ctrl_pkg::*;

        logic         toggle_q;
        logic         ps2_event;
        emu_buttons_t buttons_q;

        // A flip of the toggle bit marks one key event
        assign ps2_event = ps2_key_i.toggle != toggle_q;

        // Toggle history also follows the input during reset,
        // so no stale event fires on the first cycle out of it
        always_ff @(posedge clk_sys) begin
                toggle_q <= ps2_key_i.toggle;
        end

        // ========================================================================
        // Button state, updated only on events
        // ========================================================================
        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        buttons_q <= '0;
                end else if (ps2_event) begin
                        // Main row and numeric pad both drive the same digit
                        for (int d = 0; d < 10; d++) begin
                                if (ps2_key_i.code == PS2_DIGIT_MAIN[d] ||
                                    ps2_key_i.code == PS2_DIGIT_PAD[d]) begin
                                        buttons_q.digit[d] <= ps2_key_i.pressed;
                                end
                        end

                        if (ps2_key_i.code == PS2_STAR) begin
                                buttons_q.star <= ps2_key_i.pressed;
                        end

                        // Either shift key, one shared state
                        if (ps2_key_i.code == PS2_LSHIFT ||
                            ps2_key_i.code == PS2_RSHIFT) begin
                                buttons_q.shift <= ps2_key_i.pressed;
                        end

                        if (ps2_key_i.code == PS2_MINUS) begin
                                buttons_q.minus <= ps2_key_i.pressed;
                        end
                        // Anything else leaves the buttons alone
                end
        end

        assign buttons_o = buttons_q;

endmodule

// File: logic/joy_keypad_map.sv
/* Joystick swap and reorder into keypad vectors for both ports, with the
   emulated keyboard buttons merged in. One register stage */
`timescale 1ns/10ps

module joy_keypad_map (
        input  logic                        clk_sys,
        input  logic                        reset_i,
        input  adam_ctrl_pkg::joy_word_t    joy_a_i,
        input  adam_ctrl_pkg::joy_word_t    joy_b_i,
        input  logic                        swap_i,
        input  adam_ctrl_pkg::emu_buttons_t emu_i,
        output adam_ctrl_pkg::keypad_t      kp_0_o,
        output adam_ctrl_pkg::keypad_t      kp_1_o
);

        import adam_ctrl_pkg::*;

        joy_word_t joy_0;
        joy_word_t joy_1;
        keypad_t   emu_kp;
        keypad_t   kp_0_q;
        keypad_t   kp_1_q;

        // Joystick word: 0 right, 1 left, 2 down, 3 up, 4 fire 1, 5 fire 2,
        // 6 star, 7 number, 8..17 digits, 18 purple, 19 blue
        function automatic keypad_t joy_to_keypad(joy_word_t joy);
                keypad_t kp;
                for (int d = 0; d < 10; d++) begin
                        kp[KP_DIGIT0 + d] = joy[8 + d];
                end
                kp[KP_STAR]       = joy[6];
                kp[KP_NUMBER]     = joy[7];
                kp[KP_PURPLE]     = joy[18];
                kp[KP_BLUE]       = joy[19];
                kp[KP_DIR_UP]     = joy[3];
                kp[KP_DIR_UP + 1] = joy[2];
                kp[KP_DIR_UP + 2] = joy[1];
                kp[KP_DIR_UP + 3] = joy[0];
                kp[KP_FIRE1]      = joy[4];
                kp[KP_FIRE2]      = joy[5];
                return kp;
        endfunction

        assign joy_0 = swap_i ? joy_b_i : joy_a_i;
        assign joy_1 = swap_i ? joy_a_i : joy_b_i;

        // Keyboard contribution, same on both ports
        always_comb begin
                emu_kp = '0;
                for (int d = 0; d < 10; d++) begin
                        emu_kp[KP_DIGIT0 + d] = emu_i.digit[d];
                end
                // Shifted 8 and 3 act as star and number, not as digits
                emu_kp[KP_DIGIT0 + 8] = emu_i.digit[8] & ~emu_i.shift;
                emu_kp[KP_DIGIT0 + 3] = emu_i.digit[3] & ~emu_i.shift;
                emu_kp[KP_STAR]       = emu_i.star | (emu_i.shift & emu_i.digit[8]);
                emu_kp[KP_NUMBER]     = emu_i.minus | (emu_i.shift & emu_i.digit[3]);
        end

        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        kp_0_q <= '0;
                        kp_1_q <= '0;
                end else begin
                        kp_0_q <= joy_to_keypad(joy_0) | emu_kp;
                        kp_1_q <= joy_to_keypad(joy_1) | emu_kp;
                end
        end

        assign kp_0_o = kp_0_q;
        assign kp_1_o = kp_1_q;

endmodule

// File: logic/keypad_encoder.sv
/* One controller port. Encodes the keypad vector into the console key code
   and fire line, answering the keypad and direction select strobes */
`timescale 1ns/10ps

module keypad_encoder (
        input  logic                     clk_sys,
        input  logic                     reset_i,
        input  adam_ctrl_pkg::keypad_t   kp_i,
        input  logic                     key_sel_n_i,
        input  logic                     dir_sel_n_i,
        output adam_ctrl_pkg::port_out_t port_o
);

        import adam_ctrl_pkg::*;

        key_code_t key_code;
        key_code_t dir_code;
        logic      fire_key_n;
        logic      fire_dir_n;
        port_out_t port_q;

        // ========================================================================
        // Keypad group
        // ========================================================================
        // Walk down from blue so the lowest pressed index is written last
        always_comb begin
                key_code   = KEY_NONE;
                fire_key_n = 1'b1;
                if (!key_sel_n_i) begin
                        for (int i = KP_BLUE; i >= KP_DIGIT0; i--) begin
                                if (kp_i[i]) begin
                                        key_code = KEY_CODE_TBL[i];
                                end
                        end
                        fire_key_n = ~kp_i[KP_FIRE2];
                end
        end

        // ========================================================================
        // Direction group
        // ========================================================================
        // Up lands in the code MSB, right in the LSB
        always_comb begin
                dir_code   = KEY_NONE;
                fire_dir_n = 1'b1;
                if (!dir_sel_n_i) begin
                        dir_code   = ~kp_i[KP_DIR_UP +: 4];
                        dir_code   = {dir_code[0], dir_code[1], dir_code[2], dir_code[3]};
                        fire_dir_n = ~kp_i[KP_FIRE1];
                end
        end

        // Lines are open drain on the console side, so both groups AND
        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        port_q.code   <= KEY_NONE;
                        port_q.fire_n <= 1'b1;
                end else begin
                        port_q.code   <= key_code & dir_code;
                        port_q.fire_n <= fire_key_n & fire_dir_n;
                end
        end

        assign port_o = port_q;

endmodule

// File: logic/adam_ctrl_top.sv
/* Controller front end top level. Joysticks and PS/2 keys in, the two
   console controller ports out, strobed by the console selects */
`timescale 1ns/10ps

module adam_ctrl_top (
        input  logic                     clk_sys,
        input  logic                     reset_i,
        input  adam_ctrl_pkg::joy_word_t joy_a_i,
        input  adam_ctrl_pkg::joy_word_t joy_b_i,
        input  logic                     swap_i,
        input  adam_ctrl_pkg::ps2_key_t  ps2_key_i,
        input  logic [1:0]               key_sel_n_i,
        input  logic [1:0]               dir_sel_n_i,
        output adam_ctrl_pkg::port_out_t port_o [2]
);

        import adam_ctrl_pkg::*;

        emu_buttons_t emu_buttons;
        keypad_t      kp_0;
        keypad_t      kp_1;

        // Keyboard to held buttons
        ps2_keypad_emu u_emu (
                .clk_sys   (clk_sys),
                .reset_i   (reset_i),
                .ps2_key_i (ps2_key_i),
                .buttons_o (emu_buttons)
        );

        joy_keypad_map u_map (
                .clk_sys (clk_sys),
                .reset_i (reset_i),
                .joy_a_i (joy_a_i),
                .joy_b_i (joy_b_i),
                .swap_i  (swap_i),
                .emu_i   (emu_buttons),
                .kp_0_o  (kp_0),
                .kp_1_o  (kp_1)
        );

        // ========================================================================
        // Port encoders, one per console controller port
        // ========================================================================
        keypad_encoder u_enc_0 (
                .clk_sys     (clk_sys),
                .reset_i     (reset_i),
                .kp_i        (kp_0),
                .key_sel_n_i (key_sel_n_i[0]),
                .dir_sel_n_i (dir_sel_n_i[0]),
                .port_o      (port_o[0])
        );

        keypad_encoder u_enc_1 (
                .clk_sys     (clk_sys),
                .reset_i     (reset_i),
                .kp_i        (kp_1),
                .key_sel_n_i (key_sel_n_i[1]),
                .dir_sel_n_i (dir_sel_n_i[1]),
                .port_o      (port_o[1])
        );

endmodule

// File: bench/adam_ctrl_chk.sv
/* Assertions on the controller top level, attached by bind. Checks the
   reset state and the idle state of both ports */
`timescale 1ns/10ps

module adam_ctrl_chk (
        input logic                     clk_sys,
        input logic                     reset_i,
        input logic [1:0]               key_sel_n_i,
        input logic [1:0]               dir_sel_n_i,
        input adam_ctrl_pkg::port_out_t port_o [2]
);

        import adam_ctrl_pkg::*;

        localparam port_out_t PORT_IDLE = {KEY_NONE, 1'b1};

        // Reset forces the registered code to KEY_NONE one cycle later
        a_reset_idle_0: assert property (@(posedge clk_sys)
                reset_i |=> port_o[0].code == KEY_NONE)
                else $error("Port 0 code not KEY_NONE after a reset cycle");

        a_reset_idle_1: assert property (@(posedge clk_sys)
                reset_i |=> port_o[1].code == KEY_NONE)
                else $error("Port 1 code not KEY_NONE after a reset cycle");

        // Neither group selected, the lines float high
        a_no_sel_0: assert property (@(posedge clk_sys)
                (key_sel_n_i[0] && dir_sel_n_i[0]) |=> port_o[0] == PORT_IDLE)
                else $error("Port 0 not idle with both selects high");

        a_no_sel_1: assert property (@(posedge clk_sys)
                (key_sel_n_i[1] && dir_sel_n_i[1]) |=> port_o[1] == PORT_IDLE)
                else $error("Port 1 not idle with both selects high");

endmodule

bind adam_ctrl_top adam_ctrl_chk u_chk (
        .clk_sys     (clk_sys),
        .reset_i     (reset_i),
        .key_sel_n_i (key_sel_n_i),
        .dir_sel_n_i (dir_sel_n_i),
        .port_o      (port_o)
);

// File: bench/tb_adam_ctrl.sv
/* Testbench for the controller front end. Replays the vector file through
   the DUT and compares both console ports after each line settles */
`timescale 1ns/10ps

module tb_adam_ctrl;

        import adam_ctrl_pkg::*;

        localparam int          RESET_CYCLES = 16;
        localparam int unsigned SEED         = 32'hea1c_8691;
        localparam port_out_t   PORT_IDLE    = {KEY_NONE, 1'b1};

        // One vector line unpacked from its text columns
        typedef struct packed {
                joy_word_t   joy_a;
                joy_word_t   joy_b;
                logic        swap;
                logic [11:0] ps2_ev;
                logic [1:0]  key_sel_n;
                logic [1:0]  dir_sel_n;
                logic [7:0]  settle;
                port_out_t   exp0;
                port_out_t   exp1;
        } vector_t;

        logic       clk_sys;
        logic       reset_i;
        joy_word_t  joy_a_i;
        joy_word_t  joy_b_i;
        logic       swap_i;
        ps2_key_t   ps2_key_i;
        logic [1:0] key_sel_n_i;
        logic [1:0] dir_sel_n_i;
        port_out_t  port_o [2];

        vector_t vecs [$];
        int      max_settle;
        int      error_count;
        logic    vectors_loaded;

        adam_ctrl_top u_dut (
                .clk_sys     (clk_sys),
                .reset_i     (reset_i),
                .joy_a_i     (joy_a_i),
                .joy_b_i     (joy_b_i),
                .swap_i      (swap_i),
                .ps2_key_i   (ps2_key_i),
                .key_sel_n_i (key_sel_n_i),
                .dir_sel_n_i (dir_sel_n_i),
                .port_o      (port_o)
        );

        always #5 clk_sys = ~clk_sys;

        // ========================================================================
        // Failure reporting and compare tasks
        // ========================================================================
        task automatic stop_run();
                $display("ERRORS FOUND");
                $fatal(1, "Run stopped");
        endtask

        task automatic check_port(input int port, input port_out_t got,
                                  input port_out_t exp, input string what);
                if (got !== exp) begin
                        error_count++;
                        $display("FAILED time %0t: %s port %0d code %h fire_n %b, expected %h %b",
                                 $time, what, port, got.code, got.fire_n, exp.code, exp.fire_n);
                        stop_run();
                end
        endtask

        task automatic check_code(input int port, input key_code_t got,
                                  input key_code_t exp, input string what);
                if (got !== exp) begin
                        error_count++;
                        $display("FAILED time %0t: %s port %0d code %h, expected %h",
                                 $time, what, port, got, exp);
                        stop_run();
                end
        endtask

        // ========================================================================
        // Vector file reader
        // ========================================================================
        task automatic load_vectors();
                int          fd;
                int          n;
                string       line;
                logic [31:0] f_joy_a;
                logic [31:0] f_joy_b;
                logic [3:0]  f_swap;
                logic [11:0] f_ev;
                logic [7:0]  f_sel;
                logic [7:0]  f_settle;
                logic [3:0]  f_c0;
                logic [3:0]  f_f0;
                logic [3:0]  f_c1;
                logic [3:0]  f_f1;
                vector_t     v;
                fd = $fopen("bench/ctrl_vectors.txt", "r");
                if (fd == 0) begin
                        $display("Could not open the vector file bench/ctrl_vectors.txt");
                        stop_run();
                end
                max_settle = 0;
                while ($fgets(line, fd) != 0) begin
                        // Blank lines and comment lines carry no vector
                        if (line.len() > 1 && line.getc(0) != "#") begin
                                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                                            f_joy_a, f_joy_b, f_swap, f_ev, f_sel,
                                            f_settle, f_c0, f_f0, f_c1, f_f1);
                                if (n != 10 || f_settle < 8'd3 || f_ev[11:8] > 4'd2) begin
                                        $display("Malformed vector line: %s", line);
                                        stop_run();
                                end
                                v.joy_a       = f_joy_a;
                                v.joy_b       = f_joy_b;
                                v.swap        = f_swap[0];
                                v.ps2_ev      = f_ev;
                                v.key_sel_n   = f_sel[5:4];
                                v.dir_sel_n   = f_sel[1:0];
                                v.settle      = f_settle;
                                v.exp0.code   = f_c0;
                                v.exp0.fire_n = f_f0[0];
                                v.exp1.code   = f_c1;
                                v.exp1.fire_n = f_f1[0];
                                vecs.push_back(v);
                                if (int'(f_settle) > max_settle)
                                        max_settle = int'(f_settle);
                        end
                end
                $fclose(fd);
        endtask

        // Idle lines press random extra joystick buttons that both selects high must hide
        task automatic apply_vector(input vector_t v, input logic idle);
                logic [31:0] rnd_a;
                logic [31:0] rnd_b;
                ps2_key_t    key;
                rnd_a = idle ? $urandom() : 32'h0;
                rnd_b = idle ? $urandom() : 32'h0;
                joy_a_i     <= v.joy_a | rnd_a;
                joy_b_i     <= v.joy_b | rnd_b;
                swap_i      <= v.swap;
                key_sel_n_i <= v.key_sel_n;
                dir_sel_n_i <= v.dir_sel_n;
                if (v.ps2_ev[11:8] != 4'd0) begin
                        key          = ps2_key_i;
                        key.toggle   = ~key.toggle;
                        key.pressed  = (v.ps2_ev[11:8] == 4'd1);
                        key.extended = 1'b0;
                        key.code     = v.ps2_ev[7:0];
                        ps2_key_i   <= key;
                end
        endtask

        // ========================================================================
        // Watchdog sized from the vector count once the file is read
        // ========================================================================
        initial begin : watchdog
                int limit_cycles;
                wait (vectors_loaded === 1'b1);
                limit_cycles = vecs.size() * (max_settle + 2) + RESET_CYCLES + 16;
                repeat (limit_cycles) @(posedge clk_sys);
                $display("Simulation hung: no result after %0d clock cycles", limit_cycles);
                stop_run();
        end

        initial begin : stimulus
                int unsigned seed_val;
                logic        idle;
                vector_t     v;
                seed_val       = $urandom(SEED);
                clk_sys        = 1'b0;
                reset_i        = 1'b1;
                joy_a_i        = '0;
                joy_b_i        = '0;
                swap_i         = 1'b0;
                ps2_key_i      = '0;
                key_sel_n_i    = 2'b11;
                dir_sel_n_i    = 2'b11;
                error_count    = 0;
                vectors_loaded = 1'b0;
                load_vectors();
                vectors_loaded = 1'b1;

                repeat (RESET_CYCLES) @(posedge clk_sys);
                reset_i     <= 1'b0;
                key_sel_n_i <= 2'b00;
                dir_sel_n_i <= 2'b00;
                repeat (3) @(posedge clk_sys);
                @(negedge clk_sys);
                check_code(0, port_o[0].code, KEY_NONE, "after reset");
                check_code(1, port_o[1].code, KEY_NONE, "after reset");
                check_port(0, port_o[0], PORT_IDLE, "after reset");
                check_port(1, port_o[1], PORT_IDLE, "after reset");

                foreach (vecs[i]) begin
                        v    = vecs[i];
                        idle = (v.key_sel_n == 2'b11) && (v.dir_sel_n == 2'b11);
                        @(posedge clk_sys);
                        apply_vector(v, idle);
                        repeat (int'(v.settle)) @(posedge clk_sys);
                        @(negedge clk_sys);
                        if (idle) begin
                                check_code(0, port_o[0].code, v.exp0.code,
                                           $sformatf("idle vector %0d", i));
                                check_code(1, port_o[1].code, v.exp1.code,
                                           $sformatf("idle vector %0d", i));
                        end
                        check_port(0, port_o[0], v.exp0, $sformatf("vector %0d", i));
                        check_port(1, port_o[1], v.exp1, $sformatf("vector %0d", i));
                end

                if (error_count == 0) begin
                        $display("NO ERRORS");
                        $finish;
                end else begin
                        $display("ERRORS FOUND");
                        $fatal(1, "Mismatches seen");
                end
        end

endmodule

// File: bench/ctrl_vectors.txt
# joy_a    joy_b    swap ps2 sel settle code0 fire0 code1 fire1 (all hex)
# ps2: 000 none, 1cc make, 2cc break of code cc; sel: key_sel_n digit, dir_sel_n digit
# Idle after reset, all selects low
00000000 00000000 0 000 00 3 f 1 f 1
# Keypad select, lowest index wins
00002000 00000000 0 000 03 3 9 1 f 1
00022400 00080040 0 000 03 3 d 1 a 1
00000180 000c0000 0 000 03 3 3 1 4 1
00038000 00004200 0 000 03 3 c 1 e 1
00001008 00000800 0 000 03 3 1 1 6 1
00000020 00000010 0 000 03 3 f 0 f 1
00040000 000000c0 0 000 03 3 4 1 a 1
# Direction select, then both selects ANDed
00000008 00000001 0 000 30 3 7 1 e 1
00000006 00000010 0 000 30 3 9 1 f 0
00000038 00000400 0 000 30 3 7 0 f 1
00000208 00020021 0 000 00 3 6 1 a 0
00000010 00080002 0 000 00 3 f 0 0 1
00004008 00004001 0 000 21 3 7 1 e 1
000fffff 000fffff 0 000 33 3 f 1 f 1
# Joystick swap
00002000 00008000 1 000 03 3 c 1 9 1
00000008 00000011 1 000 30 3 e 0 7 1
00000008 00000011 0 000 30 3 7 1 e 0
00000000 00000000 1 000 33 3 f 1 f 1
# PS/2 keypad digits, shift with 8, star key
00000000 00000000 0 16b 03 4 1 1 1 1
00000000 00000000 0 26b 03 4 f 1 f 1
00000000 00000000 0 112 03 4 f 1 f 1
00000000 00000000 0 175 03 4 a 1 a 1
00000000 00000000 0 212 03 4 8 1 8 1
00000000 00000000 0 275 03 4 f 1 f 1
00000400 00000000 0 13d 03 4 d 1 c 1
00000400 00000000 0 23d 03 4 d 1 f 1
00000000 00000000 0 17c 03 4 a 1 a 1
00000000 00000000 0 27c 03 4 f 1 f 1
# Shift with 3, minus key, unmatched codes
00000000 00000000 0 159 03 4 f 1 f 1
00000000 00000000 0 126 03 4 5 1 5 1
00000000 00000000 0 11c 03 4 5 1 5 1
00000000 00000000 0 226 03 4 f 1 f 1
00000000 00000000 0 259 03 4 f 1 f 1
00000000 00000000 0 17b 03 4 5 1 5 1
00000000 00000000 0 21c 03 4 5 1 5 1
00000000 00000000 0 27b 03 4 f 1 f 1
00000000 00000000 0 133 03 4 f 1 f 1
00000000 00000000 0 169 00 4 e 1 e 1
00000000 00000000 0 269 00 4 f 1 f 1
00000000 00000000 0 000 33 3 f 1 f 1

// File: all.f
logic/adam_ctrl_pkg.sv
logic/ps2_keypad_emu.sv
logic/joy_keypad_map.sv
logic/keypad_encoder.sv
logic/adam_ctrl_top.sv
bench/adam_ctrl_chk.sv
bench/tb_adam_ctrl.sv

// File: run.sh
#!/bin/sh
# Build and run the controller front end testbench with Verilator.
# The exit status of the simulation is the pass or fail result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
        --top-module tb_adam_ctrl \
        -f all.f \
        -o sim_adam_ctrl

./obj_dir/sim_adam_ctrl

echo "Simulation finished"
